//--- Makefile
# verilator build and run of the rv64i core testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with verilator, run it, check for the pass line"
	@echo "  clean  remove the verilator build directory"

# the run passes only if the pass line shows up in the output
test:
	verilator --binary --timing --assert -j 0 --top-module npc_tb \
		-Mdir obj_dir -o npc_sim -f build.f
	@out="$$(./obj_dir/npc_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

//--- build.f
common/npc_pkg.sv
hw/ifu/npc_ifu.sv
hw/idu/npc_regfile.sv
hw/idu/npc_idu.sv
hw/exu/npc_exu.sv
hw/npc_wbu.sv
hw/npc_core.sv
dv/npc_checker.sv
dv/npc_tb.sv

//--- common/npc_pkg.sv
// shared types for the rv64i core: instruction views, stage payloads, alu ops, opcodes
package npc_pkg;

	// ****************************************
	// opcodes
	// ****************************************
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;

	// alu functions, pass_b is used by lui
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_e;

	// ****************************************
	// instruction formats
	// ****************************************
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	// jal immediate, bits scattered as in the isa
	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one word, four readings
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

	// ****************************************
	// stage payloads
	// ****************************************
	typedef struct packed {
		logic [63:0] pc;
		inst_u       inst;
	} if_id_t;

	typedef struct packed {
		logic [63:0] pc;
		logic [63:0] opa;
		logic [63:0] opb;
		alu_op_e     alu_op;
		logic [4:0]  rd;
		logic        wen;
		logic        is_jal;
		// byte offset, sign bit on top
		logic [20:0] jal_offset;
	} id_ex_t;

	typedef struct packed {
		logic [63:0] pc;
		logic [4:0]  rd;
		logic        wen;
		logic [63:0] value;
	} ex_wb_t;

	// retire port payload
	typedef struct packed {
		logic [63:0] pc;
		logic [4:0]  rd;
		logic        wen;
		logic [63:0] value;
	} retire_t;

endpackage

//--- dv/npc_checker.sv
// testbench checker: follows the retire port and compares each retirement with the expected rows
`timescale 1ns/1ns
module npc_checker #(
	parameter int n_rows = 32,
	parameter int retire_timeout = 200,
	parameter int drain_cycles = 30
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              retire_valid,
	input  npc_pkg::retire_t  retire,
	input  logic [63:0]       exp_pc [n_rows],
	input  logic [4:0]        exp_rd [n_rows],
	input  logic              exp_wen [n_rows],
	input  logic [63:0]       exp_value [n_rows],
	input  logic              exp_retires [n_rows],
	output logic              done,
	output int                n_checked,
	output int                n_mismatch,
	output int                n_other
);
	// one field against its expected value, reported on the spot
	task automatic compare_field(input string name, input int row,
			input logic [63:0] got, input logic [63:0] expected);
		if (got !== expected) begin
			n_mismatch++;
			$display("Mismatch %s at pc %h: got %h, expected %h",
				name, exp_pc[row], got, expected);
		end
	endtask

	// ****************************************
	// retire sequence walk
	// ****************************************
	initial begin : walk
		int cycles;
		bit seen;
		bit lost;
		done = 1'b0;
		n_checked = 0;
		n_mismatch = 0;
		n_other = 0;
		lost = 1'b0;
		// hold off until the core is out of reset
		cycles = 0;
		while (rst && cycles < retire_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (rst) begin
			n_other++;
			lost = 1'b1;
			$display("reset was never released");
		end
		// rows marked as never retiring are skipped, so wrong-path work shows as a pc error
		for (int r = 0; r < n_rows && !lost; r++) begin
			if (exp_retires[r]) begin
				seen = 1'b0;
				cycles = 0;
				// strobe is one cycle wide, sampled mid-cycle
				while (!seen && cycles < retire_timeout) begin
					@(negedge clk);
					seen = retire_valid;
					cycles++;
				end
				if (!seen) begin
					n_other++;
					lost = 1'b1;
					$display("no retirement arrived for the instruction at pc %h", exp_pc[r]);
				end else begin
					n_checked++;
					compare_field("retire.pc", r, retire.pc, exp_pc[r]);
					compare_field("retire.rd", r, 64'(retire.rd), 64'(exp_rd[r]));
					compare_field("retire.wen", r, 64'(retire.wen), 64'(exp_wen[r]));
					// value only matters when a register is written
					if (exp_wen[r])
						compare_field("retire.value", r, retire.value, exp_value[r]);
				end
			end
		end
		// nothing more may retire once the program is done
		cycles = 0;
		while (!lost && cycles < drain_cycles) begin
			@(negedge clk);
			if (retire_valid) begin
				n_other++;
				$display("unexpected extra retirement at pc %h", retire.pc);
			end
			cycles++;
		end
		done = 1'b1;
	end

endmodule

//--- dv/npc_tb.sv
// testbench top: clock, reset, program table, fetch responder, the core and its checker
`timescale 1ns/1ns
module npc_tb;
	import npc_pkg::*;

	localparam int n_rows = 32;
	localparam logic [63:0] prog_base = 64'h1000;
	localparam int done_timeout = 10000;
	localparam logic [31:0] nop_word = 32'h0000_0013;

	// isa opcodes for building program words
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic [63:0] fetch_pc;
	inst_u       fetch_inst = '0;
	logic        fetch_valid = 1'b0;
	logic        retire_valid;
	retire_t     retire;

	// program words and what each one should retire
	logic [31:0] prog_inst [n_rows];
	logic [63:0] exp_pc [n_rows];
	logic [4:0]  exp_rd [n_rows];
	logic        exp_wen [n_rows];
	logic [63:0] exp_value [n_rows];
	logic        exp_retires [n_rows];
	int          row_count = 0;
	integer      seed = 32'h9c1a;

	logic        chk_done;
	int          n_checked;
	int          n_mismatch;
	int          n_other;
	int          wait_cycles;

	always #10 clk = ~clk;

	// ****************************************
	// instruction encoders
	// ****************************************
	function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_reg};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, op_imm};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	// jump offset bits land scattered across the word
	function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
	endfunction

	function automatic logic [4:0] row_of(input logic [63:0] pc);
		return 5'((pc - prog_base) >> 2);
	endfunction

	task automatic add_row(input logic [31:0] word, input logic [4:0] rd, input logic wen,
			input logic [63:0] value, input logic retires);
		prog_inst[row_count] = word;
		exp_pc[row_count] = prog_base + 64'(4 * row_count);
		exp_rd[row_count] = rd;
		exp_wen[row_count] = wen;
		exp_value[row_count] = value;
		exp_retires[row_count] = retires;
		row_count++;
	endtask

	// ****************************************
	// program with hand-worked rv64i results
	// ****************************************
	task automatic load_program();
		// x1 = 5, x2 = -3
		add_row(i_type(12'd5, 5'd0, 3'b000, 5'd1), 5'd1, 1'b1, 64'h5, 1'b1);
		add_row(i_type(12'hffd, 5'd0, 3'b000, 5'd2), 5'd2, 1'b1, 64'hffff_ffff_ffff_fffd, 1'b1);
		// register-register ops
		add_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, 1'b1, 64'h2, 1'b1);
		add_row(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 1'b1, 64'h8, 1'b1);
		add_row(r_type(7'h00, 5'd1, 5'd2, 3'b010, 5'd5), 5'd5, 1'b1, 64'h1, 1'b1);
		add_row(r_type(7'h00, 5'd1, 5'd2, 3'b011, 5'd6), 5'd6, 1'b1, 64'h0, 1'b1);
		add_row(r_type(7'h20, 5'd1, 5'd2, 3'b101, 5'd7), 5'd7, 1'b1, 64'hffff_ffff_ffff_ffff, 1'b1);
		add_row(r_type(7'h00, 5'd1, 5'd2, 3'b101, 5'd8), 5'd8, 1'b1, 64'h07ff_ffff_ffff_ffff, 1'b1);
		add_row(r_type(7'h00, 5'd1, 5'd1, 3'b001, 5'd9), 5'd9, 1'b1, 64'ha0, 1'b1);
		add_row(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd10), 5'd10, 1'b1, 64'hffff_ffff_ffff_fff8, 1'b1);
		add_row(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd11), 5'd11, 1'b1, 64'hffff_ffff_ffff_fffd, 1'b1);
		add_row(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd12), 5'd12, 1'b1, 64'h5, 1'b1);
		// immediate ops and shift-immediates
		add_row(i_type(12'hffe, 5'd2, 3'b010, 5'd13), 5'd13, 1'b1, 64'h1, 1'b1);
		add_row(i_type(12'hfff, 5'd1, 3'b011, 5'd14), 5'd14, 1'b1, 64'h1, 1'b1);
		add_row(i_type(12'h7ff, 5'd1, 3'b100, 5'd15), 5'd15, 1'b1, 64'h7fa, 1'b1);
		add_row(i_type(12'h0f0, 5'd1, 3'b110, 5'd16), 5'd16, 1'b1, 64'hf5, 1'b1);
		add_row(i_type(12'h0ff, 5'd2, 3'b111, 5'd17), 5'd17, 1'b1, 64'hfd, 1'b1);
		add_row(i_type(12'd40, 5'd1, 3'b001, 5'd18), 5'd18, 1'b1, 64'h0000_0500_0000_0000, 1'b1);
		add_row(i_type(12'd60, 5'd2, 3'b101, 5'd19), 5'd19, 1'b1, 64'hf, 1'b1);
		add_row(i_type(12'h401, 5'd2, 3'b101, 5'd20), 5'd20, 1'b1, 64'hffff_ffff_ffff_fffe, 1'b1);
		// lui sign-extends, auipc at pc 0x1054
		add_row(u_type(20'h80000, 5'd21, op_lui), 5'd21, 1'b1, 64'hffff_ffff_8000_0000, 1'b1);
		add_row(u_type(20'h00001, 5'd22, op_auipc), 5'd22, 1'b1, 64'h2054, 1'b1);
		// x0 write drops, x0 read gives zero
		add_row(i_type(12'd7, 5'd0, 3'b000, 5'd0), 5'd0, 1'b0, 64'h0, 1'b1);
		add_row(r_type(7'h00, 5'd1, 5'd0, 3'b000, 5'd23), 5'd23, 1'b1, 64'h5, 1'b1);
		// back-to-back dependent chain
		add_row(i_type(12'd1, 5'd23, 3'b000, 5'd24), 5'd24, 1'b1, 64'h6, 1'b1);
		add_row(i_type(12'd1, 5'd24, 3'b000, 5'd24), 5'd24, 1'b1, 64'h7, 1'b1);
		add_row(r_type(7'h00, 5'd24, 5'd24, 3'b000, 5'd25), 5'd25, 1'b1, 64'he, 1'b1);
		// jal at 0x106c to 0x1078, two wrong-path words behind it
		add_row(j_type(21'd12, 5'd26), 5'd26, 1'b1, 64'h1070, 1'b1);
		add_row(i_type(12'd1, 5'd0, 3'b000, 5'd27), 5'd27, 1'b1, 64'h1, 1'b0);
		add_row(i_type(12'd1, 5'd0, 3'b000, 5'd28), 5'd28, 1'b1, 64'h1, 1'b0);
		add_row(i_type(12'd0, 5'd26, 3'b000, 5'd29), 5'd29, 1'b1, 64'h1070, 1'b1);
		add_row(r_type(7'h20, 5'd29, 5'd25, 3'b000, 5'd30), 5'd30, 1'b1, 64'hffff_ffff_ffff_ef9e, 1'b1);
	endtask

	// ****************************************
	// fetch responder
	// ****************************************
	// answers mid-cycle for the current fetch_pc, with random gaps
	always @(negedge clk) begin
		if (rst || fetch_pc < prog_base || fetch_pc >= prog_base + 64'(4 * n_rows)) begin
			fetch_valid <= 1'b0;
			fetch_inst <= nop_word;
		end else begin
			fetch_inst <= prog_inst[row_of(fetch_pc)];
			fetch_valid <= ($random(seed) & 32'd3) != 32'd0;
		end
	end

	npc_core #(.reset_pc(prog_base)) i_dut (
		.clk(clk), .rst(rst),
		.fetch_pc(fetch_pc), .fetch_inst(fetch_inst), .fetch_valid(fetch_valid),
		.retire_valid(retire_valid), .retire(retire)
	);

	npc_checker #(.n_rows(n_rows)) u_checker (
		.clk(clk), .rst(rst),
		.retire_valid(retire_valid), .retire(retire),
		.exp_pc(exp_pc), .exp_rd(exp_rd), .exp_wen(exp_wen),
		.exp_value(exp_value), .exp_retires(exp_retires),
		.done(chk_done), .n_checked(n_checked),
		.n_mismatch(n_mismatch), .n_other(n_other)
	);

	initial begin
		load_program();
		// reset held over five rising edges
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst <= 1'b0;
		wait_cycles = 0;
		while (!chk_done && wait_cycles < done_timeout) begin
			@(negedge clk);
			wait_cycles++;
		end
		$display("checked %0d retirements, %0d mismatches, %0d other errors",
			n_checked, n_mismatch, n_other);
		if (!chk_done) begin
			$display("checker did not finish within %0d cycles", done_timeout);
			$display("Something failed");
		end else if (n_mismatch == 0 && n_other == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- hw/exu/npc_exu.sv
// execute stage: alu, jal link and target, fetch redirect, execute/writeback slot
`timescale 1ns/1ns
module npc_exu (
	input  logic             clk,
	input  logic             rst,
	input  logic             id_valid,
	output logic             id_ready,
	input  npc_pkg::id_ex_t  id_data,
	output logic             redirect,
	output logic [63:0]      redirect_pc,
	output logic             ex_valid,
	output npc_pkg::ex_wb_t  ex_data
);
	import npc_pkg::*;

	logic [63:0] opa;
	logic [63:0] opb;
	logic [5:0]  shamt;
	logic [63:0] alu_res;
	logic [63:0] link;
	logic        accept;

	assign opa = id_data.opa;
	assign opb = id_data.opb;
	// rv64 shifts take six bits
	assign shamt = opb[5:0];

	// ****************************************
	// alu
	// ****************************************
	always_comb begin
		case (id_data.alu_op)
			alu_add:    alu_res = opa + opb;
			alu_sub:    alu_res = opa - opb;
			alu_sll:    alu_res = opa << shamt;
			alu_slt:    alu_res = {63'd0, $signed(opa) < $signed(opb)};
			alu_sltu:   alu_res = {63'd0, opa < opb};
			alu_xor:    alu_res = opa ^ opb;
			alu_srl:    alu_res = opa >> shamt;
			alu_sra:    alu_res = $signed(opa) >>> shamt;
			alu_or:     alu_res = opa | opb;
			alu_and:    alu_res = opa & opb;
			alu_pass_b: alu_res = opb;
			default:    alu_res = 64'd0;
		endcase
	end

	// ****************************************
	// jal
	// ****************************************
	assign link = id_data.pc + 64'd4;
	assign redirect_pc = id_data.pc + {{43{id_data.jal_offset[20]}}, id_data.jal_offset};

	// writeback always drains, so the slot never blocks
	assign id_ready = 1'b1;
	assign accept = id_valid && id_ready;
	assign redirect = accept && id_data.is_jal;

	always_ff @(posedge clk) begin
		if (rst)
			ex_valid <= 1'b0;
		else
			ex_valid <= accept;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ex_data.pc <= id_data.pc;
			ex_data.rd <= id_data.rd;
			ex_data.wen <= id_data.wen;
			ex_data.value <= id_data.is_jal ? link : alu_res;
		end
	end

	// the wrong-path word behind a jal never reaches this slot
	a_no_wrong_path: assert property (@(posedge clk) disable iff (rst)
		redirect |=> !id_valid);

endmodule

//--- hw/idu/npc_idu.sv
// decode stage: format decode, operand select, scoreboard stall, decode/execute slot
`timescale 1ns/1ns
module npc_idu (
	input  logic             clk,
	input  logic             rst,
	input  logic             if_valid,
	output logic             if_ready,
	input  npc_pkg::if_id_t  if_data,
	input  logic             flush,
	output logic [4:0]       rs1_addr,
	output logic [4:0]       rs2_addr,
	input  logic [63:0]      rs1_data,
	input  logic [63:0]      rs2_data,
	input  logic             rs1_busy,
	input  logic             rs2_busy,
	output logic             issue_valid,
	output logic [4:0]       issue_rd,
	output logic             id_valid,
	input  logic             id_ready,
	output npc_pkg::id_ex_t  id_data
);
	import npc_pkg::*;

	inst_u       inst;
	logic [63:0] imm_i;
	logic [63:0] imm_u;
	logic        alt;
	logic        use_rs1;
	logic        use_rs2;
	logic        hazard;
	logic        load;
	id_ex_t      dec;

	assign inst = if_data.inst;
	assign rs1_addr = inst.r.rs1;
	assign rs2_addr = inst.r.rs2;

	// ****************************************
	// immediates
	// ****************************************
	assign imm_i = {{52{inst.i.imm12[11]}}, inst.i.imm12};
	assign imm_u = {{32{inst.u.imm20[19]}}, inst.u.imm20, 12'b0};
	// inst[30] picks sub/sra, only sra for the immediate form
	assign alt = inst.r.funct7[5] && (inst.r.opcode == opc_op || inst.r.funct3 == 3'b101);

	always_comb begin
		dec = '0;
		dec.pc = if_data.pc;
		dec.rd = inst.r.rd;
		dec.alu_op = alu_add;
		dec.jal_offset = {inst.j.imm20, inst.j.imm19_12, inst.j.imm11, inst.j.imm10_1, 1'b0};
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (inst.r.opcode)
			opc_op, opc_op_imm: begin
				use_rs1 = 1'b1;
				use_rs2 = (inst.r.opcode == opc_op);
				dec.wen = 1'b1;
				dec.opa = rs1_data;
				dec.opb = use_rs2 ? rs2_data : imm_i;
				case (inst.r.funct3)
					3'b000: dec.alu_op = alt ? alu_sub : alu_add;
					3'b001: dec.alu_op = alu_sll;
					3'b010: dec.alu_op = alu_slt;
					3'b011: dec.alu_op = alu_sltu;
					3'b100: dec.alu_op = alu_xor;
					3'b101: dec.alu_op = alt ? alu_sra : alu_srl;
					3'b110: dec.alu_op = alu_or;
					default: dec.alu_op = alu_and;
				endcase
			end
			opc_lui: begin
				dec.wen = 1'b1;
				dec.opb = imm_u;
				dec.alu_op = alu_pass_b;
			end
			// relative to its own pc
			opc_auipc: begin
				dec.wen = 1'b1;
				dec.opa = if_data.pc;
				dec.opb = imm_u;
			end
			opc_jal: begin
				dec.wen = 1'b1;
				dec.is_jal = 1'b1;
			end
			// unknown encodings fall through as a no-op
			default: dec.wen = 1'b0;
		endcase
		// x0 is never a destination
		if (dec.rd == 5'd0)
			dec.wen = 1'b0;
	end

	// ****************************************
	// issue and the decode/execute slot
	// ****************************************
	assign hazard = (use_rs1 && rs1_busy) || (use_rs2 && rs2_busy);
	assign if_ready = (!id_valid || id_ready) && !hazard;
	assign load = if_valid && if_ready && !flush;

	// busy set only for real writers
	assign issue_valid = load && dec.wen;
	assign issue_rd = dec.rd;

	always_ff @(posedge clk) begin
		if (rst)
			id_valid <= 1'b0;
		else if (load)
			id_valid <= 1'b1;
		else if (flush || id_ready)
			id_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load)
			id_data <= dec;
	end

	// an older writer still in the execute slot has to hold back its readers
	a_no_raw_issue: assert property (@(posedge clk) disable iff (rst)
		load && id_valid && id_data.wen |->
			!(use_rs1 && id_data.rd == rs1_addr) && !(use_rs2 && id_data.rd == rs2_addr));

endmodule

//--- hw/idu/npc_regfile.sv
// 32x64 integer register file with the busy scoreboard that decode checks
`timescale 1ns/1ns
module npc_regfile (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  rs1_addr,
	input  logic [4:0]  rs2_addr,
	output logic [63:0] rs1_data,
	output logic [63:0] rs2_data,
	output logic        rs1_busy,
	output logic        rs2_busy,
	input  logic        issue_valid,
	input  logic [4:0]  issue_rd,
	input  logic        wb_wen,
	input  logic [4:0]  wb_rd,
	input  logic [63:0] wb_value
);
	logic [63:0] regs [32];
	// writers in flight per register, at most execute plus writeback
	logic [1:0]  pend [32];

	// ****************************************
	// read ports
	// ****************************************
	// x0 reads zero
	assign rs1_data = (rs1_addr == 5'd0) ? 64'd0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? 64'd0 : regs[rs2_addr];

	// busy while any older writer is outstanding
	assign rs1_busy = (pend[rs1_addr] != 2'd0);
	assign rs2_busy = (pend[rs2_addr] != 2'd0);

	always_ff @(posedge clk) begin
		if (wb_wen)
			regs[wb_rd] <= wb_value;
	end

	// ****************************************
	// scoreboard
	// ****************************************
	// issue counts up, writeback counts down
	// same register both ways in one cycle stays busy
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				pend[i] <= 2'd0;
		end else begin
			for (int i = 0; i < 32; i++) begin
				pend[i] <= pend[i]
					+ 2'((issue_valid && issue_rd == 5'(i)) ? 1 : 0)
					- 2'((wb_wen && wb_rd == 5'(i)) ? 1 : 0);
			end
		end
	end

	// decode clears the enable for x0, so nothing may arrive here
	a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
		wb_wen |-> wb_rd != 5'd0);

endmodule

//--- hw/ifu/npc_ifu.sv
// fetch stage: owns the pc, picks the next pc and fills the fetch/decode slot
`timescale 1ns/1ns
module npc_ifu #(
	parameter logic [63:0] reset_pc = 64'h0
) (
	input  logic             clk,
	input  logic             rst,
	output logic [63:0]      fetch_pc,
	input  npc_pkg::inst_u   fetch_inst,
	input  logic             fetch_valid,
	input  logic             redirect,
	input  logic [63:0]      redirect_pc,
	output logic             if_valid,
	input  logic             if_ready,
	output npc_pkg::if_id_t  if_data
);
	logic [63:0] pc;
	logic [63:0] next_pc;
	logic        slot_free;
	logic        capture;

	assign fetch_pc = pc;

	// slot can take a word if empty or draining this edge
	assign slot_free = !if_valid || if_ready;
	// redirect wins over any fetch this cycle
	assign capture = fetch_valid && slot_free && !redirect;

	// next pc: redirect target, else pc+4 after a capture, else hold
	always_comb begin
		next_pc = pc;
		if (redirect)
			next_pc = redirect_pc;
		else if (capture)
			next_pc = pc + 64'd4;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
			if_valid <= 1'b0;
		end else begin
			pc <= next_pc;
			if (redirect)
				if_valid <= 1'b0;
			else if (capture)
				if_valid <= 1'b1;
			else if (if_ready)
				if_valid <= 1'b0;
		end
	end

	// payload, only written on capture
	always_ff @(posedge clk) begin
		if (capture) begin
			if_data.pc <= pc;
			if_data.inst <= fetch_inst;
		end
	end

endmodule

//--- hw/npc_core.sv
// core top level: joins fetch, decode, execute, writeback and the register file
`timescale 1ns/1ns
module npc_core #(
	parameter logic [63:0] reset_pc = 64'h0
) (
	input  logic              clk,
	input  logic              rst,
	output logic [63:0]       fetch_pc,
	input  npc_pkg::inst_u    fetch_inst,
	input  logic              fetch_valid,
	output logic              retire_valid,
	output npc_pkg::retire_t  retire
);
	import npc_pkg::*;

	// ****************************************
	// stage links
	// ****************************************
	logic        if_valid;
	logic        if_ready;
	if_id_t      if_data;
	logic        id_valid;
	logic        id_ready;
	id_ex_t      id_data;
	logic        ex_valid;
	ex_wb_t      ex_data;

	// jal redirect from execute
	logic        redirect;
	logic [63:0] redirect_pc;

	// register file ports
	logic [4:0]  rs1_addr;
	logic [4:0]  rs2_addr;
	logic [63:0] rs1_data;
	logic [63:0] rs2_data;
	logic        rs1_busy;
	logic        rs2_busy;
	logic        issue_valid;
	logic [4:0]  issue_rd;
	logic        wb_wen;
	logic [4:0]  wb_rd;
	logic [63:0] wb_value;

	npc_ifu #(.reset_pc(reset_pc)) u_ifu (
		.clk(clk), .rst(rst),
		.fetch_pc(fetch_pc), .fetch_inst(fetch_inst), .fetch_valid(fetch_valid),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.if_valid(if_valid), .if_ready(if_ready), .if_data(if_data)
	);

	// decode is flushed by the same redirect
	npc_idu u_idu (
		.clk(clk), .rst(rst),
		.if_valid(if_valid), .if_ready(if_ready), .if_data(if_data),
		.flush(redirect),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
		.issue_valid(issue_valid), .issue_rd(issue_rd),
		.id_valid(id_valid), .id_ready(id_ready), .id_data(id_data)
	);

	npc_regfile u_regfile (
		.clk(clk), .rst(rst),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
		.issue_valid(issue_valid), .issue_rd(issue_rd),
		.wb_wen(wb_wen), .wb_rd(wb_rd), .wb_value(wb_value)
	);

	npc_exu u_exu (
		.clk(clk), .rst(rst),
		.id_valid(id_valid), .id_ready(id_ready), .id_data(id_data),
		.redirect(redirect), .redirect_pc(redirect_pc),
		.ex_valid(ex_valid), .ex_data(ex_data)
	);

	npc_wbu u_wbu (
		.clk(clk), .rst(rst),
		.ex_valid(ex_valid), .ex_data(ex_data),
		.wb_wen(wb_wen), .wb_rd(wb_rd), .wb_value(wb_value),
		.retire_valid(retire_valid), .retire(retire)
	);

endmodule

//--- hw/npc_wbu.sv
// writeback stage: one registered entry drives the register write and the retire strobe
`timescale 1ns/1ns
module npc_wbu (
	input  logic              clk,
	input  logic              rst,
	input  logic              ex_valid,
	input  npc_pkg::ex_wb_t   ex_data,
	output logic              wb_wen,
	output logic [4:0]        wb_rd,
	output logic [63:0]       wb_value,
	output logic              retire_valid,
	output npc_pkg::retire_t  retire
);
	// strobe is high for exactly one cycle per entry
	always_ff @(posedge clk) begin
		if (rst)
			retire_valid <= 1'b0;
		else
			retire_valid <= ex_valid;
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			retire.pc <= ex_data.pc;
			retire.rd <= ex_data.rd;
			retire.wen <= ex_data.wen;
			retire.value <= ex_data.value;
		end
	end

	// register write in the same cycle as retire
	// also releases the scoreboard entry
	assign wb_wen = retire_valid && retire.wen;
	assign wb_rd = retire.rd;
	assign wb_value = retire.value;

endmodule
